//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_ifu_top
FILELIST  = ifu_subsys.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/fetch_pkg.sv
package fetch_pkg;

  localparam int XLEN        = 32;
  localparam int ORDER_W     = 64;

  localparam int FIFO_DEPTH  = 8;
  // Leaves room for requests already on the bus
  localparam int FIFO_AFULL  = 5;
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W   = XLEN - 2 - BTB_IDX_W;

  localparam int          ROM_LATENCY = 2;
  localparam logic [31:0] ROM_SALT    = 32'hA5C3_0F69;

  typedef struct packed {
    logic [ORDER_W-1:0] order;
    logic [XLEN-1:0]    pc;
    logic               br_taken;
    logic [XLEN-1:0]    pred_next;
  } fetch_entry_t;

  typedef struct packed {
    logic               vld;
    logic [XLEN-1:0]    inst;
    logic [ORDER_W-1:0] order;
    logic [XLEN-1:0]    pc;
    logic               br_taken;
    logic [XLEN-1:0]    pred_next;
  } fetch_out_t;

  typedef struct packed {
    logic               vld;
    logic               freeze;
    logic               br_miss;
    logic [ORDER_W-1:0] order_next;
    logic [XLEN-1:0]    pc_next;
    logic               upd;
    logic [XLEN-1:0]    upd_pc;
    logic [XLEN-1:0]    upd_target;
  } exu_fb_t;

  typedef struct packed {
    logic            hit;
    logic [XLEN-1:0] target;
  } btb_pred_t;

endpackage

//--- common/wb_pkg.sv
package wb_pkg;

  localparam int WB_ADR_W = 32;
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = WB_DAT_W / 8;
  // Era tag travels on tgc and comes back with the ack
  localparam int ERA_W    = 4;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_SEL_W-1:0] sel;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
    logic                tga;
    logic [ERA_W-1:0]    tgc;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic                stall;
    logic [WB_DAT_W-1:0] dat;
    logic [ERA_W-1:0]    tgc;
  } wb_rsp_t;

endpackage

//--- hdl/fetch_fifo.sv
`timescale 1ns/10ps

module fetch_fifo #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic rst,
  input  logic clr_i,
  input  logic wr_i,
  input  T     data_i,
  input  logic rd_i,
  output T     data_o,
  output logic empty_o,
  output logic almost_full_o
);

  T                                mem [fetch_pkg::FIFO_DEPTH];
  logic [fetch_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [fetch_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [fetch_pkg::FIFO_CNT_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst || clr_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_i)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_i, rd_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage only, pointers decide what is live
  always_ff @(posedge clk)
  begin
    if (wr_i && !clr_i)
      mem[wr_ptr] <= data_i;
  end

  // Show-ahead head of queue
  assign data_o        = mem[rd_ptr];
  assign empty_o       = (count == '0);
  assign almost_full_o = (int'(count) >= fetch_pkg::FIFO_AFULL);

  a_no_overflow: assert property (@(posedge clk) disable iff (rst || clr_i)
    wr_i |-> (int'(count) < fetch_pkg::FIFO_DEPTH));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst || clr_i)
    rd_i |-> !empty_o);

endmodule

//--- hdl/ifu_top.sv
`timescale 1ns/10ps

module ifu_top (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::exu_fb_t    exu_i,
  output fetch_pkg::fetch_out_t fetch_o
);

  logic [fetch_pkg::XLEN-1:0] fetch_pc;
  fetch_pkg::btb_pred_t       pred;
  wb_pkg::wb_req_t            wb_req;
  wb_pkg::wb_rsp_t            wb_rsp;

  riscv_ifu u_riscv_ifu (
    .clk     (clk),
    .rst     (rst),
    .exu_i   (exu_i),
    .pc_o    (fetch_pc),
    .pred_i  (pred),
    .bus_o   (wb_req),
    .bus_i   (wb_rsp),
    .fetch_o (fetch_o)
  );

  // Trained from the update fields of the execute feedback
  branch_target_buffer u_btb (
    .clk    (clk),
    .rst    (rst),
    .pc_i   (fetch_pc),
    .pred_o (pred),
    .upd_i  (exu_i)
  );

  inst_rom u_inst_rom (
    .clk   (clk),
    .rst   (rst),
    .bus_i (wb_req),
    .bus_o (wb_rsp)
  );

endmodule

//--- hdl/inst_rom.sv
`timescale 1ns/10ps

module inst_rom (
  input  logic            clk,
  input  logic            rst,
  input  wb_pkg::wb_req_t bus_i,
  output wb_pkg::wb_rsp_t bus_o
);

  localparam int LAST = fetch_pkg::ROM_LATENCY - 1;

  logic [1:0]                          stall_cnt;
  logic                                stall;
  logic                                accept;
  logic [fetch_pkg::ROM_LATENCY-1:0]   vld_q;
  logic [wb_pkg::WB_ADR_W-1:0]         adr_q [fetch_pkg::ROM_LATENCY];
  logic [wb_pkg::ERA_W-1:0]            tgc_q [fetch_pkg::ROM_LATENCY];

  // One stall cycle out of four
  assign stall  = (stall_cnt == 2'd3);
  assign accept = bus_i.cyc & bus_i.stb & ~stall;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stall_cnt <= '0;
      vld_q     <= '0;
    end
    else
    begin
      stall_cnt <= stall_cnt + 1'b1;
      vld_q[0]  <= accept;
      for (int i = 1; i < fetch_pkg::ROM_LATENCY; i++)
        vld_q[i] <= vld_q[i-1];
    end
  end

  always_ff @(posedge clk)
  begin
    adr_q[0] <= bus_i.adr;
    tgc_q[0] <= bus_i.tgc;
    for (int i = 1; i < fetch_pkg::ROM_LATENCY; i++)
    begin
      adr_q[i] <= adr_q[i-1];
      tgc_q[i] <= tgc_q[i-1];
    end
  end

  always_comb
  begin
    bus_o.ack   = vld_q[LAST];
    bus_o.stall = stall;
    bus_o.dat   = adr_q[LAST] ^ fetch_pkg::ROM_SALT;
    bus_o.tgc   = tgc_q[LAST];
  end

endmodule

//--- ifu/branch_target_buffer.sv
`timescale 1ns/10ps

module branch_target_buffer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  output fetch_pkg::btb_pred_t       pred_o,
  input  fetch_pkg::exu_fb_t         upd_i
);

  logic [fetch_pkg::BTB_ENTRIES-1:0] valid_q;
  logic [fetch_pkg::BTB_TAG_W-1:0]   tag_q    [fetch_pkg::BTB_ENTRIES];
  logic [fetch_pkg::XLEN-1:0]        target_q [fetch_pkg::BTB_ENTRIES];

  logic [fetch_pkg::BTB_IDX_W-1:0]   rd_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0]   rd_tag;
  logic [fetch_pkg::BTB_IDX_W-1:0]   wr_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0]   wr_tag;
  logic                              wr_en;

  // Word offset bits are skipped for the index
  assign rd_idx = pc_i[2 +: fetch_pkg::BTB_IDX_W];
  assign rd_tag = pc_i[fetch_pkg::XLEN-1 : 2+fetch_pkg::BTB_IDX_W];
  assign wr_idx = upd_i.upd_pc[2 +: fetch_pkg::BTB_IDX_W];
  assign wr_tag = upd_i.upd_pc[fetch_pkg::XLEN-1 : 2+fetch_pkg::BTB_IDX_W];
  assign wr_en  = upd_i.vld & upd_i.upd;

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_q <= '0;
    else if (wr_en)
      valid_q[wr_idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd_i.upd_target;
    end
  end

  // Same-cycle lookup for the fetch PC
  always_comb
  begin
    pred_o.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    pred_o.target = target_q[rd_idx];
  end

endmodule

//--- ifu/riscv_ifu.sv
`timescale 1ns/10ps

module riscv_ifu (
  input  logic                       clk,
  input  logic                       rst,
  input  fetch_pkg::exu_fb_t         exu_i,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  input  fetch_pkg::btb_pred_t       pred_i,
  output wb_pkg::wb_req_t            bus_o,
  input  wb_pkg::wb_rsp_t            bus_i,
  output fetch_pkg::fetch_out_t      fetch_o
);

  logic [fetch_pkg::XLEN-1:0]    pc_q;
  logic [fetch_pkg::XLEN-1:0]    pc_next;
  logic [fetch_pkg::ORDER_W-1:0] order_q;
  logic [wb_pkg::ERA_W-1:0]      era_q;
  logic                          run_q;
  logic                          clr_q;
  logic                          issue;
  logic                          miss;
  logic                          frozen;
  logic                          pop;

  fetch_pkg::fetch_entry_t       meta_in_q;
  fetch_pkg::fetch_entry_t       meta_out;
  logic                          meta_wr_q;
  logic                          meta_empty;
  logic                          meta_afull;

  logic [fetch_pkg::XLEN-1:0]    data_in_q;
  logic [fetch_pkg::XLEN-1:0]    data_out;
  logic                          data_wr_q;
  logic                          data_empty;

  assign miss    = exu_i.vld & exu_i.br_miss;
  assign frozen  = exu_i.vld & exu_i.freeze;
  assign issue   = run_q & ~meta_afull & ~bus_i.stall;
  assign pop     = ~meta_empty & ~data_empty & ~clr_q & ~frozen & ~miss;
  assign pc_next = pred_i.hit ? pred_i.target : pc_q + 32'd4;
  assign pc_o    = pc_q;

  always_comb
  begin
    bus_o     = '0;
    bus_o.cyc = issue;
    bus_o.stb = issue;
    bus_o.sel = '1;
    bus_o.adr = pc_q;
    bus_o.tga = pred_i.hit;
    bus_o.tgc = era_q;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q      <= '0;
      order_q   <= '0;
      era_q     <= '0;
      run_q     <= 1'b0;
      clr_q     <= 1'b0;
      meta_wr_q <= 1'b0;
      data_wr_q <= 1'b0;
    end
    else
    begin
      run_q     <= 1'b1;
      clr_q     <= miss;
      meta_wr_q <= issue;
      // Responses from an older era are dropped here
      data_wr_q <= bus_i.ack & (bus_i.tgc == era_q);
      if (miss)
      begin
        pc_q    <= exu_i.pc_next;
        order_q <= exu_i.order_next;
        era_q   <= era_q + 1'b1;
      end
      else if (issue)
      begin
        pc_q    <= pc_next;
        order_q <= order_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    meta_in_q.order     <= order_q;
    meta_in_q.pc        <= pc_q;
    meta_in_q.br_taken  <= pred_i.hit;
    meta_in_q.pred_next <= pc_next;
    data_in_q           <= bus_i.dat;
  end

  fetch_fifo #(.T(fetch_pkg::fetch_entry_t)) u_meta_fifo (
    .clk           (clk),
    .rst           (rst),
    .clr_i         (clr_q),
    .wr_i          (meta_wr_q),
    .data_i        (meta_in_q),
    .rd_i          (pop),
    .data_o        (meta_out),
    .empty_o       (meta_empty),
    .almost_full_o (meta_afull)
  );

  // Data never runs ahead of metadata, so only the metadata fill gates issue
  fetch_fifo #(.T(logic [fetch_pkg::XLEN-1:0])) u_data_fifo (
    .clk           (clk),
    .rst           (rst),
    .clr_i         (clr_q),
    .wr_i          (data_wr_q),
    .data_i        (data_in_q),
    .rd_i          (pop),
    .data_o        (data_out),
    .empty_o       (data_empty),
    .almost_full_o ()
  );

  // Decode register holds its contents while frozen
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      fetch_o.inst      <= data_out;
      fetch_o.order     <= meta_out.order;
      fetch_o.pc        <= meta_out.pc;
      fetch_o.br_taken  <= meta_out.br_taken;
      fetch_o.pred_next <= meta_out.pred_next;
    end
    if (rst || miss)
      fetch_o.vld <= 1'b0;
    else if (pop)
      fetch_o.vld <= 1'b1;
    else if (!frozen)
      fetch_o.vld <= 1'b0;
  end

  // Every returned word finds its fetch entry already queued
  a_data_has_meta: assert property (@(posedge clk) disable iff (rst)
    (data_wr_q && !clr_q) |-> !meta_empty);

  a_stb_rst: assert property (@(posedge clk) rst |=> !bus_o.stb);

endmodule

//--- ifu_subsys.f
common/wb_pkg.sv
common/fetch_pkg.sv
hdl/fetch_fifo.sv
ifu/branch_target_buffer.sv
ifu/riscv_ifu.sv
hdl/inst_rom.sv
hdl/ifu_top.sv
sim/tb_clk_gen.sv
sim/tb_ifu_top.sv

//--- sim/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Reset released just after an edge, like every other input
  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES)
      @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

//--- sim/tb_ifu_top.sv
`timescale 1ns/10ps

module tb_ifu_top;

  localparam int         RST_CYCLES     = 8;
  localparam int         NUM_STEPS      = 10;
  localparam int         TAIL_MARGIN    = 100;
  localparam int         MIN_DELIVERIES = 60;
  localparam int         MIN_TAKEN      = 3;
  localparam logic [1:0] FRZ_NONE       = 2'd0;
  localparam logic [1:0] FRZ_HOLD       = 2'd1;
  localparam logic [1:0] FRZ_RAND       = 2'd2;

  typedef struct packed {
    logic [1:0]                    frz_mode;
    logic                          miss;
    logic [fetch_pkg::XLEN-1:0]    pc_next;
    logic [fetch_pkg::ORDER_W-1:0] order_next;
    logic                          upd;
    logic [fetch_pkg::XLEN-1:0]    upd_pc;
    logic [fetch_pkg::XLEN-1:0]    upd_target;
    logic [15:0]                   cycles;
  } step_t;

  logic                  clk;
  logic                  rst;
  fetch_pkg::exu_fb_t    exu;
  fetch_pkg::fetch_out_t fetch_o;

  step_t                         steps [NUM_STEPS];
  logic [15:0]                   lfsr;
  logic                          model_valid  [fetch_pkg::BTB_ENTRIES];
  logic [fetch_pkg::XLEN-1:0]    model_pc     [fetch_pkg::BTB_ENTRIES];
  logic [fetch_pkg::XLEN-1:0]    model_target [fetch_pkg::BTB_ENTRIES];
  logic [fetch_pkg::XLEN-1:0]    exp_pc;
  logic [fetch_pkg::ORDER_W-1:0] exp_order;
  fetch_pkg::exu_fb_t            seen_fb;
  fetch_pkg::fetch_out_t         prev_out;
  int                            deliveries;
  int                            taken_cnt;
  int                            cycle_cnt;
  int                            timeout_limit;

  tb_clk_gen #(.PERIOD_NS(8.0), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  ifu_top u_ifu_top (
    .clk     (clk),
    .rst     (rst),
    .exu_i   (exu),
    .fetch_o (fetch_o)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  function automatic int row_of(input logic [fetch_pkg::XLEN-1:0] pc);
    return int'((pc >> 2) % fetch_pkg::BTB_ENTRIES);
  endfunction

  function automatic logic predict_hit(input logic [fetch_pkg::XLEN-1:0] pc);
    return model_valid[row_of(pc)] && (model_pc[row_of(pc)][31:2] == pc[31:2]);
  endfunction

  task automatic check_value(input string name, input logic [191:0] actual,
                             input logic [191:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %s: actual %0h, expected %0h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic check_delivery();
    logic                       taken;
    logic [fetch_pkg::XLEN-1:0] next_pc;
    taken   = predict_hit(exp_pc);
    next_pc = taken ? model_target[row_of(exp_pc)] : exp_pc + 32'd4;
    check_value("fetch_o.pc", fetch_o.pc, exp_pc);
    check_value("fetch_o.order", fetch_o.order, exp_order);
    check_value("fetch_o.inst", fetch_o.inst, exp_pc ^ fetch_pkg::ROM_SALT);
    check_value("fetch_o.br_taken", fetch_o.br_taken, taken);
    check_value("fetch_o.pred_next", fetch_o.pred_next, next_pc);
    deliveries++;
    if (taken)
      taken_cnt++;
    exp_pc    = next_pc;
    exp_order = exp_order + 1'b1;
  endtask

  task automatic drive_cycle(input step_t st, input logic first);
    logic frz;
    frz = 1'b0;
    if (st.frz_mode == FRZ_HOLD)
      frz = 1'b1;
    else if (st.frz_mode == FRZ_RAND)
    begin
      lfsr = lfsr_next(lfsr);
      frz  = lfsr[0];
    end
    exu            = '0;
    exu.freeze     = frz;
    exu.br_miss    = first & st.miss;
    exu.order_next = st.order_next;
    exu.pc_next    = st.pc_next;
    exu.upd        = first & st.upd;
    exu.upd_pc     = st.upd_pc;
    exu.upd_target = st.upd_target;
    exu.vld        = exu.freeze | exu.br_miss | exu.upd;
  endtask

  // Feedback driven in one cycle takes effect at the next edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (seen_fb.vld && seen_fb.br_miss)
      begin
        check_value("fetch_o.vld", fetch_o.vld, 1'b0);
        exp_pc    = seen_fb.pc_next;
        exp_order = seen_fb.order_next;
      end
      else if (seen_fb.vld && seen_fb.freeze)
        check_value("fetch_o", fetch_o, prev_out);
      else if (fetch_o.vld)
        check_delivery();
      if (seen_fb.vld && seen_fb.upd)
      begin
        model_valid[row_of(seen_fb.upd_pc)]  = 1'b1;
        model_pc[row_of(seen_fb.upd_pc)]     = seen_fb.upd_pc;
        model_target[row_of(seen_fb.upd_pc)] = seen_fb.upd_target;
      end
    end
    prev_out = fetch_o;
    seen_fb  = exu;
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit)
    begin
      $display("Timeout after %0d cycles before the test sequence finished", cycle_cnt);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    int target;
    exu        = '0;
    seen_fb    = '0;
    lfsr       = 16'd15305;
    exp_pc     = '0;
    exp_order  = '0;
    deliveries = 0;
    taken_cnt  = 0;
    cycle_cnt  = 0;
    for (int i = 0; i < fetch_pkg::BTB_ENTRIES; i++)
      model_valid[i] = 1'b0;

    // Freeze, miss, miss PC, miss order, train, train PC, target, cycles
    steps[0] = '{FRZ_NONE, 1'b0, 32'h000, 64'd0,    1'b0, 32'h000, 32'h000, 16'd40};
    steps[1] = '{FRZ_HOLD, 1'b0, 32'h000, 64'd0,    1'b0, 32'h000, 32'h000, 16'd12};
    steps[2] = '{FRZ_NONE, 1'b0, 32'h000, 64'd0,    1'b0, 32'h000, 32'h000, 16'd20};
    steps[3] = '{FRZ_NONE, 1'b1, 32'h400, 64'd1000, 1'b0, 32'h000, 32'h000, 16'd24};
    steps[4] = '{FRZ_NONE, 1'b1, 32'h100, 64'd2000, 1'b1, 32'h108, 32'h200, 16'd30};
    steps[5] = '{FRZ_HOLD, 1'b0, 32'h000, 64'd0,    1'b0, 32'h000, 32'h000, 16'd6};
    steps[6] = '{FRZ_NONE, 1'b1, 32'h104, 64'd3000, 1'b0, 32'h000, 32'h000, 16'd20};
    steps[7] = '{FRZ_RAND, 1'b0, 32'h000, 64'd0,    1'b0, 32'h000, 32'h000, 16'd120};
    steps[8] = '{FRZ_RAND, 1'b1, 32'h1F8, 64'd5000, 1'b1, 32'h1FC, 32'h100, 16'd150};
    steps[9] = '{FRZ_NONE, 1'b0, 32'h000, 64'd0,    1'b0, 32'h000, 32'h000, 16'd24};

    timeout_limit = RST_CYCLES + TAIL_MARGIN;
    for (int s = 0; s < NUM_STEPS; s++)
      timeout_limit += int'(steps[s].cycles);

    wait (rst === 1'b0);
    for (int s = 0; s < NUM_STEPS; s++)
    begin
      for (int c = 0; c < int'(steps[s].cycles); c++)
      begin
        @(posedge clk);
        #1;
        drive_cycle(steps[s], c == 0);
      end
    end
    @(posedge clk);
    #1;
    exu = '0;

    // A few more deliveries after all feedback is released
    target = deliveries + 4;
    wait (deliveries >= target);

    if (deliveries >= MIN_DELIVERIES && taken_cnt >= MIN_TAKEN)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      $display("Only %0d instructions delivered, %0d with a predicted branch",
               deliveries, taken_cnt);
      $display("Simulation FAILED");
      $fatal(1, "too few deliveries");
    end
  end

endmodule
